// ==== gb_sys_defines.svh ====
`ifndef GB_SYS_DEFINES_SVH
`define GB_SYS_DEFINES_SVH

// cpu bus widths
`define GB_ADDR_W        16
`define GB_DATA_W        8

// ---------------------------------------------------------------------
// i/o registers, low byte within page ff
// ---------------------------------------------------------------------
`define GB_IO_PAGE       8'hFF
`define GB_REG_JOYP      8'h00
`define GB_REG_IF        8'h0F
`define GB_REG_KEY0      8'h4C   // cgb/dmg mode
`define GB_REG_KEY1      8'h4D   // speed switch
`define GB_REG_VBK       8'h4F
`define GB_REG_BOOT      8'h50
`define GB_REG_SVBK      8'h70
`define GB_REG_FF72      8'h72
`define GB_REG_FF73      8'h73
`define GB_REG_FF74      8'h74   // cgb mode only
`define GB_REG_FF75      8'h75
`define GB_REG_IE        8'hFF

// interrupt vectors, highest priority first
`define GB_VEC_VBLANK    8'h40
`define GB_VEC_LCDC      8'h48
`define GB_VEC_TIMER     8'h50
`define GB_VEC_SERIAL    8'h58
`define GB_VEC_JOYPAD    8'h60

// ram geometry
`define GB_WRAM_AW       15      // 8 banks of 4k
`define GB_ZPRAM_AW      7
`define GB_ZPRAM_SIZE    127     // ff80..fffe

// reset and idle values
`define GB_RST_SVBK      3'd1
`define GB_RST_BOOT      1'b1
`define GB_JOY_IDLE      4'hF    // joypad lines idle high
`define GB_BOOT_OFF_CGB  8'h11   // ff50 value that unmaps the cgb boot rom

`endif

// ==== gb_bus_pkg.sv ====
package gb_bus_pkg;

	// register view: page byte and register byte
	typedef struct packed {
		logic [7:0]  io_page;
		logic [7:0]  io_reg;
	} gb_addr_io_t;

	// memory view: 8k region, 4k half, offset in the half
	typedef struct packed {
		logic [2:0]  region;   // 110/111 = wram and echo
		logic        bank_hi;  // 1 = switchable wram bank
		logic [11:0] offset;
	} gb_addr_map_t;

	// one cpu address, decoded both ways
	typedef union packed {
		gb_addr_io_t  io;
		gb_addr_map_t map;
	} gb_addr_u;

	// index of the cgb scratch regs, ff72 = 0 .. ff75 = 3
	typedef logic [1:0] gb_ffx_t;

endpackage

// ==== gb_irq_pkg.sv ====
package gb_irq_pkg;

	localparam int GB_IRQ_N = 5;

	// sources in priority order, index = IF/IE bit
	typedef enum logic [2:0] {
		IRQ_VBLANK = 3'd0,
		IRQ_LCDC   = 3'd1,
		IRQ_TIMER  = 3'd2,
		IRQ_SERIAL = 3'd3,
		IRQ_JOYPAD = 3'd4
	} gb_irq_src_e;

	// one bit per source
	typedef logic [GB_IRQ_N-1:0] gb_irq_vec_t;

endpackage

// ==== gb_bus_decode.sv ====
`timescale 1ns/1ps
`include "gb_sys_defines.svh"

module gb_bus_decode import gb_bus_pkg::*, gb_irq_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	input  logic                  is_gbc_i,
	input  logic                  cgb_mode_i,
	input  logic [`GB_ADDR_W-1:0] cpu_addr_i,
	input  logic                  cpu_wr_n_i,
	input  logic                  cpu_iorq_n_i,
	input  logic                  cpu_m1_n_i,
	// read sources
	input  logic [`GB_DATA_W-1:0] irq_vec_i,
	input  logic [`GB_DATA_W-1:0] ie_i,
	input  gb_irq_vec_t           if_i,
	input  logic [`GB_DATA_W-1:0] sys_rdata_i,
	input  logic [`GB_DATA_W-1:0] ram_rdata_i,
	// selects
	output logic                  sel_ie_o,
	output logic                  sel_if_o,
	output logic                  sel_key0_o,
	output logic                  sel_key1_o,
	output logic                  sel_vbk_o,
	output logic                  sel_boot_o,
	output logic                  sel_svbk_o,
	output logic                  sel_joyp_o,
	output gb_ffx_t               sel_ffx_o,
	output logic                  sel_ffx_v_o,
	output logic                  sel_wram_o,
	output logic                  sel_zpram_o,
	output logic                  wr_stb_o,
	output logic                  ack_stb_o,
	output logic                  ack_o,
	output logic [`GB_DATA_W-1:0] cpu_di_o
);

	gb_addr_u a;
	logic     io_pg;       // page ff
	logic     cgb_io;      // cgb-only reg visible
	logic     sys_hit;
	logic     wr_n_q;
	logic     ack_q;

	assign a      = cpu_addr_i;
	assign io_pg  = (a.io.io_page == `GB_IO_PAGE);
	assign cgb_io = io_pg && is_gbc_i;

	// ------------------------------------------------------------------
	// register selects
	// ------------------------------------------------------------------
	assign sel_ie_o   = io_pg && (a.io.io_reg == `GB_REG_IE);
	assign sel_if_o   = io_pg && (a.io.io_reg == `GB_REG_IF);
	assign sel_joyp_o = io_pg && (a.io.io_reg == `GB_REG_JOYP);
	assign sel_boot_o = io_pg && (a.io.io_reg == `GB_REG_BOOT);
	assign sel_key0_o = cgb_io && (a.io.io_reg == `GB_REG_KEY0); // boot rom gate in regs
	assign sel_vbk_o  = cgb_io && (a.io.io_reg == `GB_REG_VBK);
	assign sel_key1_o = cgb_io && cgb_mode_i && (a.io.io_reg == `GB_REG_KEY1);
	assign sel_svbk_o = cgb_io && cgb_mode_i && (a.io.io_reg == `GB_REG_SVBK);

	// scratch regs, ff74 only in cgb mode
	assign sel_ffx_v_o = cgb_io && ((a.io.io_reg == `GB_REG_FF72) ||
		(a.io.io_reg == `GB_REG_FF73) || (a.io.io_reg == `GB_REG_FF75) ||
		(cgb_mode_i && (a.io.io_reg == `GB_REG_FF74)));
	assign sel_ffx_o = a.io.io_reg[1:0] - 2'd2; // 72 -> 0 .. 75 -> 3

	// c000-fdff, echo above e000 drops fe00 and up
	assign sel_wram_o = (a.map.region[2:1] == 2'b11) &&
		!(a.map.region[0] && a.map.bank_hi && (&a.map.offset[11:9]));
	assign sel_zpram_o = io_pg && a.io.io_reg[7] && (a.io.io_reg != `GB_REG_IE);

	// ------------------------------------------------------------------
	// write strobe and ack end
	// ------------------------------------------------------------------
	assign ack_o     = !cpu_iorq_n_i && !cpu_m1_n_i;
	assign ack_stb_o = ack_q && !ack_o; // ack just ended

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			wr_n_q   <= 1'b0;
			wr_stb_o <= 1'b0;
			ack_q    <= 1'b0;
		end else begin
			wr_n_q   <= cpu_wr_n_i;
			wr_stb_o <= wr_n_q && !cpu_wr_n_i; // first low sample
			ack_q    <= ack_o;
		end
	end

	// ------------------------------------------------------------------
	// cpu read mux
	// ------------------------------------------------------------------
	assign sys_hit = sel_key0_o | sel_key1_o | sel_vbk_o | sel_svbk_o |
		sel_joyp_o | sel_ffx_v_o;

	always_comb begin
		if (ack_o)
			cpu_di_o = irq_vec_i;           // vector fetch
		else if (sel_if_o)
			cpu_di_o = {3'b111, if_i};
		else if (sel_ie_o)
			cpu_di_o = ie_i;
		else if (sys_hit)
			cpu_di_o = sys_rdata_i;
		else if (sel_wram_o || sel_zpram_o)
			cpu_di_o = ram_rdata_i;         // registered in ram
		else
			cpu_di_o = 8'hFF;               // unmapped
	end

endmodule

// ==== gb_irq_ctrl.sv ====
`timescale 1ns/1ps
`include "gb_sys_defines.svh"

module gb_irq_ctrl import gb_irq_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	input  logic                  vblank_irq_i,
	input  logic                  video_irq_i,
	input  logic                  timer_irq_i,
	input  logic                  serial_irq_i,
	input  logic [3:0]            joy_din_i,
	input  logic                  sel_ie_i,
	input  logic                  sel_if_i,
	input  logic                  wr_stb_i,
	input  logic                  ack_stb_i,
	input  logic [`GB_DATA_W-1:0] cpu_do_i,
	output logic [`GB_DATA_W-1:0] ie_o,
	output gb_irq_vec_t           if_o,
	output logic [`GB_DATA_W-1:0] irq_vec_o,
	output logic                  irq_n_o
);

	logic [3:0]  src;
	logic [3:0]  src_q;
	logic [3:0]  joy_s1;
	logic [3:0]  joy_s2;
	logic [3:0]  joy_q;
	gb_irq_vec_t set_v;
	gb_irq_vec_t pend;
	gb_irq_vec_t ack_sel;   // one-hot, top pending source

	function automatic logic [7:0] irq_vector(gb_irq_src_e s);
		case (s)
			IRQ_VBLANK: return `GB_VEC_VBLANK;
			IRQ_LCDC:   return `GB_VEC_LCDC;
			IRQ_TIMER:  return `GB_VEC_TIMER;
			IRQ_SERIAL: return `GB_VEC_SERIAL;
			default:    return `GB_VEC_JOYPAD;
		endcase
	endfunction

	// ------------------------------------------------------------------
	// source edges
	// ------------------------------------------------------------------
	assign src = {serial_irq_i, timer_irq_i, video_irq_i, vblank_irq_i};

	// rising edge on a source, falling edge on any synced joypad line
	assign set_v = {|(joy_q & ~joy_s2), src & ~src_q};

	// ------------------------------------------------------------------
	// priority, lowest bit wins
	// ------------------------------------------------------------------
	assign pend    = ie_o[GB_IRQ_N-1:0] & if_o;
	assign irq_n_o = ~|pend;

	always_comb begin
		ack_sel   = '0;
		irq_vec_o = 8'h00;     // nothing pending
		for (int i = GB_IRQ_N - 1; i >= 0; i--) begin
			if (pend[i]) begin
				ack_sel    = '0;
				ack_sel[i] = 1'b1;
				irq_vec_o  = irq_vector(gb_irq_src_e'(i));
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ie_o   <= '0;
			if_o   <= '0;
			src_q  <= '0;
			joy_s1 <= `GB_JOY_IDLE;
			joy_s2 <= `GB_JOY_IDLE;
			joy_q  <= `GB_JOY_IDLE;
		end else begin
			src_q  <= src;
			joy_s1 <= joy_din_i;  // two-flop sync
			joy_s2 <= joy_s1;
			joy_q  <= joy_s2;     // previous synced value

			// set, then ack clear, a cpu write replaces both
			if (ack_stb_i)
				if_o <= (if_o | set_v) & ~ack_sel;
			else
				if_o <= if_o | set_v;
			if (sel_if_i && wr_stb_i)
				if_o <= cpu_do_i[GB_IRQ_N-1:0];

			if (sel_ie_i && wr_stb_i)
				ie_o <= cpu_do_i;  // all 8 bits kept
		end
	end

endmodule

// ==== gb_sys_regs.sv ====
`timescale 1ns/1ps
`include "gb_sys_defines.svh"

module gb_sys_regs import gb_bus_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	input  logic                  is_gbc_i,
	input  logic                  sel_key0_i,
	input  logic                  sel_key1_i,
	input  logic                  sel_vbk_i,
	input  logic                  sel_boot_i,
	input  logic                  sel_svbk_i,
	input  logic                  sel_joyp_i,
	input  gb_ffx_t               sel_ffx_i,
	input  logic                  sel_ffx_v_i,
	input  logic                  wr_stb_i,
	input  logic [`GB_DATA_W-1:0] cpu_do_i,
	input  logic                  cpu_stop_i,
	input  logic [3:0]            joy_din_i,
	output logic [`GB_DATA_W-1:0] sys_rdata_o,
	output logic                  cgb_mode_o,
	output logic [2:0]            wram_bank_o,
	output logic                  speed_o,
	output logic [1:0]            joy_p54_o,
	output logic                  boot_rom_en_o
);

	logic [1:0]            key0_r;     // 00 cgb, 01 dmg
	logic                  prepare_r;  // KEY1 bit 0
	logic                  vbk_r;
	logic [`GB_DATA_W-1:0] ffx_r [0:3];
	logic                  ff75_sel;
	logic                  boot_off;

	assign cgb_mode_o = (key0_r == 2'b00) || boot_rom_en_o;
	assign ff75_sel   = (sel_ffx_i == 2'd3);

	// 11 on cgb, bit 0 set on dmg
	assign boot_off = is_gbc_i ? (cpu_do_i == `GB_BOOT_OFF_CGB) : cpu_do_i[0];

	// ------------------------------------------------------------------
	// register writes
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			key0_r        <= 2'b00;
			prepare_r     <= 1'b0;
			speed_o       <= 1'b0;
			wram_bank_o   <= `GB_RST_SVBK;
			vbk_r         <= 1'b0;
			joy_p54_o     <= 2'b00;
			boot_rom_en_o <= `GB_RST_BOOT;
			for (int i = 0; i < 4; i++)
				ffx_r[i] <= '0;
		end else begin
			if (sel_key0_i && wr_stb_i && boot_rom_en_o)
				key0_r <= cpu_do_i[3:2];   // locked once boot rom is off
			if (sel_key1_i && wr_stb_i)
				prepare_r <= cpu_do_i[0];
			// stop with prepare set flips the speed
			if (is_gbc_i && prepare_r && cpu_stop_i) begin
				speed_o   <= ~speed_o;
				prepare_r <= 1'b0;
			end
			if (sel_svbk_i && wr_stb_i)
				wram_bank_o <= (cpu_do_i[2:0] == 3'd0) ? 3'd1 : cpu_do_i[2:0]; // 0 -> 1
			if (sel_vbk_i && wr_stb_i)
				vbk_r <= cpu_do_i[0];
			if (sel_joyp_i && wr_stb_i)
				joy_p54_o <= cpu_do_i[5:4];
			if (sel_ffx_v_i && wr_stb_i)
				ffx_r[sel_ffx_i] <= ff75_sel ? (cpu_do_i & 8'h70) : cpu_do_i; // ff75 keeps 6:4
			if (sel_boot_i && wr_stb_i && boot_off)
				boot_rom_en_o <= 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// read back
	// ------------------------------------------------------------------
	always_comb begin
		if (sel_key0_i)
			sys_rdata_o = boot_rom_en_o ? {4'hF, key0_r, 2'b10} : 8'hFF;
		else if (sel_key1_i)
			sys_rdata_o = {speed_o, 6'h3F, prepare_r};
		else if (sel_svbk_i)
			sys_rdata_o = {5'h1F, wram_bank_o};
		else if (sel_vbk_i)
			sys_rdata_o = {7'h7F, vbk_r};
		else if (sel_joyp_i)
			sys_rdata_o = {2'b11, joy_p54_o, joy_din_i};
		else if (sel_ffx_v_i)
			sys_rdata_o = ffx_r[sel_ffx_i] | (ff75_sel ? 8'h8F : 8'h00);
		else
			sys_rdata_o = 8'hFF;
	end

endmodule

// ==== gb_int_ram.sv ====
`timescale 1ns/1ps
`include "gb_sys_defines.svh"

module gb_int_ram import gb_bus_pkg::*; (
	input  logic                  clk_sys,
	input  logic [`GB_ADDR_W-1:0] cpu_addr_i,
	input  logic [`GB_DATA_W-1:0] cpu_do_i,
	input  logic                  sel_wram_i,
	input  logic                  sel_zpram_i,
	input  logic                  wr_stb_i,
	input  logic [2:0]            wram_bank_i,
	output logic [`GB_DATA_W-1:0] ram_rdata_o
);

	gb_addr_u                  a;
	logic [`GB_WRAM_AW-1:0]    wram_addr;
	logic [`GB_ZPRAM_AW-1:0]   zp_addr;
	logic [`GB_DATA_W-1:0]     wram [0:(1 << `GB_WRAM_AW) - 1];
	logic [`GB_DATA_W-1:0]     zpram [0:`GB_ZPRAM_SIZE-1];
	logic [`GB_DATA_W-1:0]     wram_q;
	logic [`GB_DATA_W-1:0]     zp_q;
	logic                      sel_wram_q;
	logic                      sel_zp_q;

	assign a = cpu_addr_i;

	// c000-cfff bank 0, d000-dfff svbk bank, echo follows the same split
	assign wram_addr = {a.map.bank_hi ? wram_bank_i : 3'd0, a.map.offset};
	assign zp_addr   = a.io.io_reg[`GB_ZPRAM_AW-1:0];

	// ------------------------------------------------------------------
	// work ram, 32k
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (sel_wram_i && wr_stb_i)
			wram[wram_addr] <= cpu_do_i;
		wram_q <= wram[wram_addr];
	end

	// zero page, ff80-fffe
	always_ff @(posedge clk_sys) begin
		if (sel_zpram_i && wr_stb_i)
			zpram[zp_addr] <= cpu_do_i;
		zp_q <= zpram[zp_addr];
	end

	// select follows the data by one cycle
	always_ff @(posedge clk_sys) begin
		sel_wram_q <= sel_wram_i;
		sel_zp_q   <= sel_zpram_i;
	end

	assign ram_rdata_o = sel_zp_q   ? zp_q :
	                     sel_wram_q ? wram_q : 8'hFF;

endmodule

// ==== gb_sys_top.sv ====
`timescale 1ns/1ps
`include "gb_sys_defines.svh"

module gb_sys_top import gb_bus_pkg::*, gb_irq_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	input  logic                  is_gbc_i,
	input  logic [`GB_ADDR_W-1:0] cpu_addr_i,
	input  logic [`GB_DATA_W-1:0] cpu_do_i,
	input  logic                  cpu_wr_n_i,
	input  logic                  cpu_iorq_n_i,
	input  logic                  cpu_m1_n_i,
	input  logic                  cpu_stop_i,
	input  logic                  vblank_irq_i,
	input  logic                  video_irq_i,
	input  logic                  timer_irq_i,
	input  logic                  serial_irq_i,
	input  logic [3:0]            joy_din_i,
	output logic [`GB_DATA_W-1:0] cpu_di_o,
	output logic                  irq_n_o,
	output logic                  speed_o,
	output logic [1:0]            joy_p54_o,
	output logic                  boot_rom_en_o
);

	logic                  sel_ie, sel_if, sel_key0, sel_key1, sel_vbk, sel_boot;
	logic                  sel_svbk, sel_joyp, sel_ffx_v, sel_wram, sel_zpram;
	gb_ffx_t               sel_ffx;
	logic                  wr_stb, ack_stb, cgb_mode;
	logic [2:0]            wram_bank;
	logic [`GB_DATA_W-1:0] ie, irq_vec, sys_rdata, ram_rdata;
	gb_irq_vec_t           if_r;

	// ------------------------------------------------------------------
	// bus side
	// ------------------------------------------------------------------
	gb_bus_decode u_decode (
		.clk_sys      (clk_sys),      .reset_ss     (reset_ss),
		.is_gbc_i     (is_gbc_i),     .cgb_mode_i   (cgb_mode),
		.cpu_addr_i   (cpu_addr_i),   .cpu_wr_n_i   (cpu_wr_n_i),
		.cpu_iorq_n_i (cpu_iorq_n_i), .cpu_m1_n_i   (cpu_m1_n_i),
		.irq_vec_i    (irq_vec),      .ie_i         (ie),
		.if_i         (if_r),         .sys_rdata_i  (sys_rdata),
		.ram_rdata_i  (ram_rdata),
		.sel_ie_o     (sel_ie),       .sel_if_o     (sel_if),
		.sel_key0_o   (sel_key0),     .sel_key1_o   (sel_key1),
		.sel_vbk_o    (sel_vbk),      .sel_boot_o   (sel_boot),
		.sel_svbk_o   (sel_svbk),     .sel_joyp_o   (sel_joyp),
		.sel_ffx_o    (sel_ffx),      .sel_ffx_v_o  (sel_ffx_v),
		.sel_wram_o   (sel_wram),     .sel_zpram_o  (sel_zpram),
		.wr_stb_o     (wr_stb),       .ack_stb_o    (ack_stb),
		.ack_o        (),             .cpu_di_o     (cpu_di_o)
	);

	gb_sys_regs u_regs (
		.clk_sys     (clk_sys),     .reset_ss      (reset_ss),
		.is_gbc_i    (is_gbc_i),    .sel_key0_i    (sel_key0),
		.sel_key1_i  (sel_key1),    .sel_vbk_i     (sel_vbk),
		.sel_boot_i  (sel_boot),    .sel_svbk_i    (sel_svbk),
		.sel_joyp_i  (sel_joyp),    .sel_ffx_i     (sel_ffx),
		.sel_ffx_v_i (sel_ffx_v),   .wr_stb_i      (wr_stb),
		.cpu_do_i    (cpu_do_i),    .cpu_stop_i    (cpu_stop_i),
		.joy_din_i   (joy_din_i),   .sys_rdata_o   (sys_rdata),
		.cgb_mode_o  (cgb_mode),    .wram_bank_o   (wram_bank),
		.speed_o     (speed_o),     .joy_p54_o     (joy_p54_o),
		.boot_rom_en_o (boot_rom_en_o)
	);

	// ------------------------------------------------------------------
	// interrupts and memory
	// ------------------------------------------------------------------
	gb_irq_ctrl u_irq (
		.clk_sys      (clk_sys),      .reset_ss     (reset_ss),
		.vblank_irq_i (vblank_irq_i), .video_irq_i  (video_irq_i),
		.timer_irq_i  (timer_irq_i),  .serial_irq_i (serial_irq_i),
		.joy_din_i    (joy_din_i),    .sel_ie_i     (sel_ie),
		.sel_if_i     (sel_if),       .wr_stb_i     (wr_stb),
		.ack_stb_i    (ack_stb),      .cpu_do_i     (cpu_do_i),
		.ie_o         (ie),           .if_o         (if_r),
		.irq_vec_o    (irq_vec),      .irq_n_o      (irq_n_o)
	);

	gb_int_ram u_ram (
		.clk_sys     (clk_sys),     .cpu_addr_i  (cpu_addr_i),
		.cpu_do_i    (cpu_do_i),    .sel_wram_i  (sel_wram),
		.sel_zpram_i (sel_zpram),   .wr_stb_i    (wr_stb),
		.wram_bank_i (wram_bank),   .ram_rdata_o (ram_rdata)
	);

endmodule

// ==== gb_sys_assert.sv ====
`timescale 1ns/1ps

module gb_sys_assert #(
	parameter bit IRQ_SIDE = 1'b1     // 1 = irq ctrl rules, 0 = sys reg rules
) (
	input logic       clk_sys,
	input logic       reset_ss,
	input logic       irq_n,
	input logic [4:0] ie_lo,
	input logic [4:0] if_v,
	input logic [2:0] bank,
	input logic       speed,
	input logic       stop
);

	generate
		if (IRQ_SIDE) begin : g_irq
			// line low exactly when an enabled flag is pending
			a_irq_line: assert property (@(posedge clk_sys) disable iff (reset_ss)
				irq_n == ~|(ie_lo & if_v))
				else $error("irq_n does not match ie & if");
		end else begin : g_regs
			a_bank_nz: assert property (@(posedge clk_sys) disable iff (reset_ss)
				bank != 3'd0)
				else $error("wram bank is zero");
			// speed only flips right after a stop
			a_speed_stop: assert property (@(posedge clk_sys) disable iff (reset_ss)
				(speed != $past(speed)) |-> $past(stop))
				else $error("speed changed without stop");
		end
	endgenerate

endmodule

bind gb_irq_ctrl gb_sys_assert #(.IRQ_SIDE(1'b1)) u_irq_assert (
	.clk_sys (clk_sys), .reset_ss (reset_ss), .irq_n (irq_n_o),
	.ie_lo   (ie_o[4:0]), .if_v (if_o), .bank (3'd1),
	.speed   (1'b0), .stop (1'b0)
);

bind gb_sys_regs gb_sys_assert #(.IRQ_SIDE(1'b0)) u_regs_assert (
	.clk_sys (clk_sys), .reset_ss (reset_ss), .irq_n (1'b1),
	.ie_lo   (5'd0), .if_v (5'd0), .bank (wram_bank_o),
	.speed   (speed_o), .stop (cpu_stop_i)
);

// ==== tb_gb_sys.sv ====
`timescale 1ns/1ps
`include "gb_sys_defines.svh"

module tb_gb_sys;

	logic        clk_sys, reset_ss, is_gbc_i;
	logic [15:0] cpu_addr_i;
	logic [7:0]  cpu_do_i;
	logic        cpu_wr_n_i, cpu_iorq_n_i, cpu_m1_n_i, cpu_stop_i;
	logic        vblank_irq_i, video_irq_i, timer_irq_i, serial_irq_i;
	logic [3:0]  joy_din_i;
	logic [7:0]  cpu_di_o;
	logic        irq_n_o, speed_o, boot_rom_en_o;
	logic [1:0]  joy_p54_o;

	// model state
	logic [7:0]  m_wram [0:32767];
	logic [7:0]  m_zp [0:126];
	logic [7:0]  m_ie, m_ffx [0:3];
	logic [4:0]  m_if;
	logic [2:0]  m_svbk;
	logic [1:0]  m_key0, m_p54;
	logic        m_prep, m_speed, m_vbk, m_boot;
	logic [31:0] lfsr;
	// check mailbox filled at negedge and drained at posedge
	string       chk_name;
	logic [7:0]  chk_exp, chk_act;
	logic        chk_req;
	int          checks, errors, timeouts;
	logic [11:0] d_off [0:3][0:2];
	logic [11:0] c_off [0:2];
	logic [2:0]  banks [0:3];
	logic [15:0] zp_a [0:7];
	logic [4:0]  pend;
	int          lo;

	gb_sys_top DUT (.*);

	always #50 clk_sys = ~clk_sys;

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic m_cgb();
		return (m_key0 == 2'b00) || m_boot;
	endfunction

	function automatic logic [14:0] wram_idx(input logic [15:0] a);
		return {a[12] ? m_svbk : 3'd0, a[11:0]}; // upper 4k is banked
	endfunction

	// ------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------
	function automatic logic [7:0] ref_read(input logic [15:0] a);
		if (a[15:8] == 8'hFF) begin
			case (a[7:0])
				8'hFF: return m_ie;
				8'h0F: return {3'b111, m_if};
				8'h00: return {2'b11, m_p54, joy_din_i};
				8'h4D: return m_cgb() ? {m_speed, 6'h3F, m_prep} : 8'hFF;
				8'h70: return m_cgb() ? {5'h1F, m_svbk} : 8'hFF;
				8'h4F: return {7'h7F, m_vbk};
				8'h72, 8'h73: return m_ffx[a[7:0] - 8'h72];
				8'h74: return m_cgb() ? m_ffx[2] : 8'hFF;
				8'h75: return m_ffx[3] | 8'h8F;  // fixed ones around 6:4
				default: return a[7] ? m_zp[a[6:0]] : 8'hFF;
			endcase
		end
		if (a >= 16'hC000 && a < 16'hFE00)
			return m_wram[wram_idx(a)];
		return 8'hFF;
	endfunction

	task automatic model_write(input logic [15:0] a, input logic [7:0] d);
		if (a[15:8] == 8'hFF) begin
			case (a[7:0])
				8'hFF: m_ie = d;
				8'h0F: m_if = d[4:0];
				8'h00: m_p54 = d[5:4];
				8'h50: if (d == 8'h11) m_boot = 1'b0;
				8'h4C: if (m_boot) m_key0 = d[3:2];
				8'h4D: if (m_cgb()) m_prep = d[0];
				8'h70: if (m_cgb()) m_svbk = (d[2:0] == 3'd0) ? 3'd1 : d[2:0];
				8'h4F: m_vbk = d[0];
				8'h72, 8'h73: m_ffx[a[7:0] - 8'h72] = d;
				8'h74: if (m_cgb()) m_ffx[2] = d;
				8'h75: m_ffx[3] = d & 8'h70;
				default: if (a[7]) m_zp[a[6:0]] = d;
			endcase
		end else if (a >= 16'hC000 && a < 16'hFE00) begin
			m_wram[wram_idx(a)] = d;
		end
	endtask

	// ------------------------------------------------------------------
	// compare process
	// ------------------------------------------------------------------
	always @(posedge clk_sys) begin
		if (chk_req) begin
			chk_req = 1'b0;
			checks++;
			if (chk_exp !== chk_act) begin
				errors++;
				$display("CHECK FAILED %s: expected %02h actual %02h",
					chk_name, chk_exp, chk_act);
			end
		end
	end

	task automatic post_check(input string name, input logic [7:0] e, input logic [7:0] act);
		chk_name = name;   // caller sits at a negedge
		chk_exp  = e;
		chk_act  = act;
		chk_req  = 1'b1;
		@(posedge clk_sys);
	endtask

	// write held low for two edges
	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		cpu_addr_i <= a;
		cpu_do_i   <= d;
		cpu_wr_n_i <= 1'b0;
		repeat (2) @(posedge clk_sys);
		cpu_wr_n_i <= 1'b1;
		@(posedge clk_sys);
		model_write(a, d);
	endtask

	task automatic bus_read(input string name, input logic [15:0] a);
		@(posedge clk_sys);
		cpu_addr_i <= a;
		repeat (2) @(posedge clk_sys);   // address held 2 cycles
		@(negedge clk_sys);
		post_check(name, ref_read(a), cpu_di_o);
	endtask

	task automatic irq_ack(input string name, input logic [7:0] vec);
		@(posedge clk_sys);
		cpu_iorq_n_i <= 1'b0;
		cpu_m1_n_i   <= 1'b0;
		@(negedge clk_sys);
		post_check(name, vec, cpu_di_o);
		cpu_iorq_n_i <= 1'b1;           // flag clears on the edge after ack ends
		cpu_m1_n_i   <= 1'b1;
		@(posedge clk_sys);
	endtask

	task automatic wait_irq_low(input string name);
		int n;
		n = 0;
		while (irq_n_o !== 1'b0 && n < 20) begin
			@(posedge clk_sys);
			n++;
		end
		if (irq_n_o !== 1'b0) begin
			timeouts++;
			$display("timeout in %s: irq_n_o never went low", name);
		end
	endtask

	task automatic wait_speed(input logic want);
		int n;
		n = 0;
		while (speed_o !== want && n < 20) begin
			@(posedge clk_sys);
			n++;
		end
		if (speed_o !== want) begin
			timeouts++;
			$display("timeout: speed_o did not switch to %0d", want);
		end
	endtask

	task automatic stop_pulse();
		@(posedge clk_sys);
		cpu_stop_i <= 1'b1;
		@(posedge clk_sys);
		cpu_stop_i <= 1'b0;
	endtask

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	initial begin
		clk_sys = 0;
		reset_ss = 1;
		is_gbc_i = 1;
		cpu_addr_i = 16'h0000;
		cpu_do_i = 0;
		cpu_wr_n_i = 1;
		cpu_iorq_n_i = 1;
		cpu_m1_n_i = 1;
		cpu_stop_i = 0;
		vblank_irq_i = 0;
		video_irq_i = 0;
		timer_irq_i = 0;
		serial_irq_i = 0;
		joy_din_i = 4'hF;
		lfsr = 32'h7144;
		chk_req = 0;
		checks = 0;
		errors = 0;
		timeouts = 0;
		m_ie = 0;
		m_if = 0;
		m_svbk = 3'd1;
		m_key0 = 0;
		m_p54 = 0;
		m_prep = 0;
		m_speed = 0;
		m_vbk = 0;
		m_boot = 1;
		for (int i = 0; i < 4; i++)
			m_ffx[i] = 8'h00;
		banks[0] = 3'd2;
		banks[1] = 3'd5;
		banks[2] = 3'd7;
		banks[3] = 3'd3;
		repeat (5) @(posedge clk_sys);
		reset_ss <= 1'b0;
		repeat (2) @(posedge clk_sys);

		// register read-back
		foreach (m_ffx[i]) begin
			bus_write(16'hFF72 + i, rand_bits(8));
			bus_read("ffx", 16'hFF72 + i);
		end
		bus_write(16'hFFFF, rand_bits(8));
		bus_read("ie", 16'hFFFF);
		bus_write(16'hFF0F, rand_bits(8));
		bus_read("if", 16'hFF0F);
		bus_write(16'hFF4F, rand_bits(8));
		bus_read("vbk", 16'hFF4F);
		bus_write(16'hFF00, rand_bits(8));
		bus_read("joyp", 16'hFF00);
		@(negedge clk_sys);
		post_check("joy_p54_o", {6'd0, m_p54}, {6'd0, joy_p54_o});
		bus_write(16'hFF70, rand_bits(8));
		bus_read("svbk", 16'hFF70);
		bus_write(16'hFF70, 8'h00);
		bus_read("svbk zero", 16'hFF70);
		bus_write(16'hFF4D, rand_bits(8));
		bus_read("key1", 16'hFF4D);

		// wram banking with upper 4k offsets kept below fe00
		for (int j = 0; j < 3; j++) begin
			c_off[j] = rand_bits(12) & 12'hDFF;
			bus_write(16'hC000 | c_off[j], rand_bits(8));
		end
		for (int b = 0; b < 4; b++) begin
			bus_write(16'hFF70, banks[b]);
			for (int j = 0; j < 3; j++) begin
				d_off[b][j] = rand_bits(12) & 12'hDFF;
				bus_write(16'hD000 | d_off[b][j], rand_bits(8));
			end
		end
		for (int b = 0; b < 4; b++) begin
			bus_write(16'hFF70, banks[b]);
			for (int j = 0; j < 3; j++) begin
				bus_read("wram bank", 16'hD000 | d_off[b][j]);
				bus_read("wram echo bank", 16'hF000 | d_off[b][j]);
			end
			bus_read("wram bank0", 16'hC000 | c_off[b % 3]);
		end
		for (int j = 0; j < 3; j++)
			bus_read("wram echo bank0", 16'hE000 | c_off[j]);

		// zero page
		for (int j = 0; j < 8; j++) begin
			zp_a[j] = 16'hFF80 + (rand_bits(7) % 127);
			bus_write(zp_a[j], rand_bits(8));
		end
		for (int j = 0; j < 8; j++)
			bus_read("zpram", zp_a[j]);
		bus_read("ie above zpram", 16'hFFFF);

		// ------------------------------------------------------------------
		// interrupts
		// ------------------------------------------------------------------
		bus_write(16'hFF0F, 8'h00);
		bus_write(16'hFFFF, rand_bits(8) | 8'h04);
		@(posedge clk_sys);
		vblank_irq_i <= 1;
		video_irq_i  <= 1;
		timer_irq_i  <= 1;
		serial_irq_i <= 1;
		@(posedge clk_sys);
		vblank_irq_i <= 0;
		video_irq_i  <= 0;
		timer_irq_i  <= 0;
		serial_irq_i <= 0;
		m_if = m_if | 5'h0F;
		wait_irq_low("irq pulse");
		bus_read("if after pulses", 16'hFF0F);
		pend = m_ie[4:0] & m_if;
		while (pend != 5'd0) begin
			lo = 0;
			while (!pend[lo]) lo++;               // lowest bit has priority
			irq_ack("ack vector", 8'h40 + 8 * lo);
			m_if[lo] = 1'b0;
			bus_read("if after ack", 16'hFF0F);
			pend = m_ie[4:0] & m_if;
		end
		@(negedge clk_sys);
		post_check("irq_n idle", 8'h01, {7'd0, irq_n_o});
		// joypad falling edge sets bit 4
		bus_write(16'hFF0F, 8'h00);
		bus_write(16'hFFFF, 8'h10);
		@(posedge clk_sys);
		joy_din_i <= 4'hE;
		wait_irq_low("joypad edge");
		m_if = m_if | 5'h10;
		bus_read("if joypad", 16'hFF0F);
		@(posedge clk_sys);
		joy_din_i <= 4'hF;

		// speed switch
		bus_write(16'hFF4D, 8'h01);
		stop_pulse();
		wait_speed(1'b1);
		m_speed = 1'b1;
		m_prep  = 1'b0;
		bus_read("key1 after switch", 16'hFF4D);
		stop_pulse();                          // no prepare so no change
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		post_check("speed hold", 8'h01, {7'd0, speed_o});

		// boot and mode
		bus_write(16'hFF4C, 8'h04);            // dmg mode bits
		bus_write(16'hFF50, 8'h11);
		@(negedge clk_sys);
		post_check("boot off", 8'h00, {7'd0, boot_rom_en_o});
		bus_read("svbk dmg", 16'hFF70);
		bus_read("key1 dmg", 16'hFF4D);
		bus_write(16'hFF4C, 8'h00);            // locked now
		bus_read("svbk after key0", 16'hFF70);

		repeat (3) @(posedge clk_sys);
		$display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== gb_sys.f ====
+incdir+.
gb_bus_pkg.sv
gb_irq_pkg.sv
gb_bus_decode.sv
gb_irq_ctrl.sv
gb_sys_regs.sv
gb_int_ram.sv
gb_sys_top.sv
gb_sys_assert.sv
tb_gb_sys.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the gb_sys testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_gb_sys -f gb_sys.f -o sim_gb_sys
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_gb_sys > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST PASSED" sim.log; then
	exit 0
fi
exit 1
